// ==== bench/noteVectors.svh ====
`ifndef NOTE_VECTORS_SVH
`define NOTE_VECTORS_SVH

// expected outcome of one run
typedef struct packed {
    logic [binQty-1:0]   kept;    // bins strictly above the floor
    logic [sumWidth-1:0] newSum;  // sum of the lowered bins
    levelFrame_t         levels;
} expResult_t;

localparam int rowQty  = 8;
localparam int handQty = 5;   // rows from here on are random

string      rowName [rowQty];
ampFrame_t  rowAmps [rowQty];
expResult_t rowExp  [rowQty];

// floor is a fifth of the total, level is the bin's share of the lowered sum in eighths
function automatic expResult_t refRule(input ampFrame_t amps);
    expResult_t r;
    longint     total;
    longint     floorVal;
    longint     lowered [binQty];
    r     = '0;
    total = 0;
    for (int b = 0; b < binQty; b++)
        total += longint'(amps[b]);
    floorVal = (total * floorNum) / (1 << floorShift);  // rounded down
    for (int b = 0; b < binQty; b++) begin
        lowered[b] = 0;
        if (longint'(amps[b]) > floorVal) begin  // a bin at the floor is dropped
            r.kept[b]  = 1'b1;
            lowered[b] = longint'(amps[b]) - floorVal;
        end
        r.newSum += sumWidth'(lowered[b]);
    end
    for (int b = 0; b < binQty; b++) begin
        if (r.newSum != 0) begin
            // a bin is at most the whole sum, so this tops out at levelMax
            r.levels[b] = levelWidth'(lowered[b] * levelMax / longint'(r.newSum));
        end
    end
    return r;
endfunction

task automatic buildTable();
    for (int r = 0; r < rowQty; r++)
        rowAmps[r] = '0;
    rowName[0] = "singleBin";
    rowAmps[0][5] = 16'h4000;   // lone bin goes to the top of the bar
    rowName[1] = "allZero";
    rowName[2] = "atThreshold";  // sum 20480, floor 4100
    rowAmps[2][0]  = 16'd7000;
    rowAmps[2][3]  = 16'd4100;
    rowAmps[2][7]  = 16'd4100;
    rowAmps[2][10] = 16'd5280;
    rowName[3] = "allMax";       // input sum near full scale, every bin under the floor
    rowAmps[3] = '1;
    rowName[4] = "twoMax";       // largest lowered sum
    rowAmps[4][2] = 16'hffff;
    rowAmps[4][9] = 16'hfffe;
    rowAmps[4][4] = 16'h0100;
    for (int r = handQty; r < rowQty; r++) begin
        rowName[r] = $sformatf("random%0d", r - handQty);
        for (int b = 0; b < binQty; b++) begin
            // mostly quiet bins, now and then a loud one
            rowAmps[r][b] = ($urandom_range(3) == 0) ? amp_t'($urandom)
                                                     : amp_t'($urandom_range(4095));
        end
    end
    for (int r = 0; r < rowQty; r++)
        rowExp[r] = refRule(rowAmps[r]);
endtask

`endif

// ==== bench/visualizerTb.sv ====
`timescale 1ns/1ps

module visualizerTb;
    import fixPointPkg::*;
    import apbBusPkg::*;

    `include "noteVectors.svh"

    localparam int runCycles    = 1 + 4 + 4 * binQty;  // start pulse, filter, divider
    localparam int busTimeout   = 4;
    localparam int frameTimeout = 80;

    logic        clk;
    logic        rst;
    apbReq_t     apbReq;
    apbRsp_t     apbRsp;
    levelFrame_t ledLevels;
    logic        frameValid;
    int          errCount;
    int          checkCount;

    visualizerTop i_visualizerTop (
        .clk          (clk),
        .rst          (rst),
        .apbReq_i     (apbReq),
        .apbRsp_o     (apbRsp),
        .ledLevels_o  (ledLevels),
        .frameValid_o (frameValid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic checkVal(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("Error %s: expected %0h, actual %0h", name, expVal, actVal);
        end
    endtask

    task automatic abortRun(input string why);
        errCount++;
        $display("%s", why);
        $display("checks %0d, errors %0d", checkCount, errCount);
        $display("Some tests failed");
        $finish;
    endtask

    // setup then access phase, response sampled 1 ns into the access half cycle
    task automatic transfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waitCnt;
        @(negedge clk);
        apbReq.paddr   = addr;
        apbReq.pwrite  = wr;
        apbReq.pwdata  = wdata;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        @(negedge clk);
        apbReq.penable = 1'b1;
        waitCnt = 0;
        #1;
        while (!apbRsp.pready && waitCnt < busTimeout) begin
            @(negedge clk);
            #1;
            waitCnt++;
        end
        if (!apbRsp.pready) begin
            abortRun($sformatf("APB transfer to address %0h never completed", addr));
        end else begin
            rdata = apbRsp.prdata;
            err   = apbRsp.pslverr;
            @(posedge clk);  // access completes here
            @(negedge clk);
            apbReq.psel    = 1'b0;
            apbReq.penable = 1'b0;
        end
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] discard;
        transfer(addr, 1'b1, data, discard, err);
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [31:0] data, output logic err);
        transfer(addr, 1'b0, 32'h0, data, err);
    endtask

    task automatic loadAmps(input string name, input ampFrame_t amps);
        logic err;
        for (int b = 0; b < binQty; b++) begin
            writeReg(ampBase + 8'(4 * b), 32'(amps[b]), err);
            checkVal($sformatf("%s amp[%0d] pslverr", name, b), 0, err);
        end
    endtask

    // edges from the completing control write to the first edge that sees frameValid
    task automatic waitFrame(output int latency);
        int cnt;
        cnt = 0;
        while (!frameValid && cnt < frameTimeout) begin
            @(negedge clk);
            cnt++;
        end
        if (!frameValid) begin
            abortRun("frameValid did not arrive within the timeout");
        end else begin
            latency = cnt + 1;  // the next rising edge consumes it
        end
    endtask

    task automatic checkResult(input string name, input ampFrame_t amps, input expResult_t e);
        logic [31:0] data;
        logic        err;
        checkVal({name, " led port"}, e.levels, ledLevels);
        for (int b = 0; b < binQty; b++) begin
            readReg(levelBase + 8'(4 * b), data, err);
            checkVal($sformatf("%s level[%0d]", name, b), e.levels[b], data);
            readReg(fastBase + 8'(4 * b), data, err);
            checkVal($sformatf("%s fast[%0d]", name, b), e.kept[b] ? amps[b] : 16'h0, data);
        end
        readReg(sumAddr, data, err);
        checkVal({name, " new sum"}, e.newSum, data);
        checkVal({name, " sum pslverr"}, 0, err);
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        int          latency;
        ampFrame_t   newAmps;
        expResult_t  newExp;
        void'($urandom(32'h7c6e));
        errCount   = 0;
        checkCount = 0;
        apbReq     = '0;
        rst        = 1'b1;
        buildTable();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        checkVal("reset frameValid", 0, frameValid);
        checkVal("reset levels", 0, ledLevels);
        checkVal("reset pslverr", 0, apbRsp.pslverr);
        readReg(statusAddr, data, err);
        checkVal("reset status", 0, data);

        // each row: load, start, time the run, read everything back
        for (int r = 0; r < rowQty; r++) begin
            loadAmps(rowName[r], rowAmps[r]);
            writeReg(ctrlAddr, 32'h1, err);
            waitFrame(latency);
            checkVal({rowName[r], " latency"}, runCycles, latency);
            readReg(statusAddr, data, err);
            checkVal({rowName[r], " status"}, 32'h2, data);  // ready, not busy
            checkResult(rowName[r], rowAmps[r], rowExp[r]);
        end

        // second start and new amplitudes while a run is in flight
        newAmps     = rowAmps[2];
        newAmps[0]  = 16'd9000;
        newAmps[1]  = 16'd300;
        newAmps[11] = 16'd2500;
        newExp      = refRule(newAmps);
        loadAmps("busyRun", rowAmps[2]);
        writeReg(ctrlAddr, 32'h1, err);
        readReg(statusAddr, data, err);
        checkVal("busyRun status", 32'h1, data);  // busy, ready cleared
        writeReg(ctrlAddr, 32'h1, err);
        writeReg(ampBase, 32'(newAmps[0]), err);
        writeReg(ampBase + 8'h04, 32'(newAmps[1]), err);
        writeReg(ampBase + 8'h2c, 32'(newAmps[11]), err);
        waitFrame(latency);
        checkResult("busyRun", rowAmps[2], rowExp[2]);
        writeReg(ctrlAddr, 32'h1, err);
        waitFrame(latency);
        checkVal("afterBusy latency", runCycles, latency);
        checkResult("afterBusy", newAmps, newExp);

        // unmapped and unaligned accesses
        readReg(8'h38, data, err);
        checkVal("read 38 pslverr", 1, err);
        checkVal("read 38 data", 0, data);
        readReg(8'h70, data, err);  // level bank past bin 11
        checkVal("read 70 pslverr", 1, err);
        checkVal("read 70 data", 0, data);
        writeReg(8'h31, 32'h1, err);  // unaligned alias of the control word
        checkVal("write 31 pslverr", 1, err);
        writeReg(8'hf0, 32'hffff_ffff, err);
        checkVal("write f0 pslverr", 1, err);
        readReg(statusAddr, data, err);
        checkVal("status after bad writes", 32'h2, data);  // no run started
        for (int b = 0; b < binQty; b++) begin
            readReg(ampBase + 8'(4 * b), data, err);
            checkVal($sformatf("amp[%0d] after bad writes", b), newAmps[b], data);
        end
        readReg(sumAddr, data, err);
        checkVal("sum after bad writes", newExp.newSum, data);
        checkVal("levels after bad writes", newExp.levels, ledLevels);

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+bench
logic/fixPointPkg.sv
logic/apbBusPkg.sv
logic/apbNoteRegs.sv
logic/ampFloorFilter.sv
logic/ledLevelMapper.sv
logic/visualizerTop.sv
bench/visualizerTb.sv

// ==== logic/ampFloorFilter.sv ====
`timescale 1ns/1ps

module ampFloorFilter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  fixPointPkg::ampFrame_t  amps_i,
    output fixPointPkg::filterOut_t res_o,
    output logic                    valid_o
);
    import fixPointPkg::*;

    logic [3:0] validPipe;  // start_i delayed by one per stage

    // stage 0
    logic [sumWidth-1:0] sumS0;
    logic [sumWidth-1:0] sumQ;
    ampFrame_t           ampsD1;

    // stage 1
    logic [sumWidth+7:0] prod;  // sum times an 8-bit constant
    logic [sumWidth-1:0] thr;
    logic [sumWidth-1:0] thrQ;
    ampFrame_t           ampsD2;

    // stage 2
    ampFrame_t red;
    ampFrame_t fast;
    ampFrame_t redQ;
    ampFrame_t fastQ;

    // stage 3
    logic [sumWidth-1:0] newSum;

    always_comb begin
        sumS0 = '0;
        for (int b = 0; b < binQty; b++) begin
            sumS0 += sumWidth'(amps_i[b]);
        end

        // threshold is about 0.2 of the total
        prod = sumQ * 8'(floorNum);
        thr  = sumWidth'(prod >> floorShift);

        // bins at or below the threshold are dropped
        for (int b = 0; b < binQty; b++) begin
            if (sumWidth'(ampsD2[b]) > thrQ) begin
                red[b]  = amp_t'(sumWidth'(ampsD2[b]) - thrQ);  // positive, fits an amp
                fast[b] = ampsD2[b];
            end else begin
                red[b]  = '0;
                fast[b] = '0;
            end
        end

        newSum = '0;
        for (int b = 0; b < binQty; b++) begin
            newSum += sumWidth'(redQ[b]);
        end
    end

    // datapath, amplitudes travel with their stage so a new frame can enter every cycle
    always_ff @(posedge clk) begin
        sumQ   <= sumS0;
        ampsD1 <= amps_i;
        thrQ   <= thr;
        ampsD2 <= ampsD1;
        redQ   <= red;
        fastQ  <= fast;
        res_o.reduced <= redQ;
        res_o.fast    <= fastQ;
        res_o.newSum  <= newSum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[2:0], start_i};
        end
    end

    assign valid_o = validPipe[3];  // four cycles after start

endmodule

// ==== logic/apbBusPkg.sv ====
package apbBusPkg;

    localparam int addrWidth = 8;
    localparam int dataWidth = 32;

    // register map, one 32-bit word per entry, banks are 64 bytes apart
    localparam logic [addrWidth-1:0] ampBase    = 8'h00;  // 12 words up to 0x2c
    localparam logic [addrWidth-1:0] ctrlAddr   = 8'h30;  // bit 0 starts a run
    localparam logic [addrWidth-1:0] statusAddr = 8'h34;  // bit 0 busy, bit 1 ready
    localparam logic [addrWidth-1:0] levelBase  = 8'h40;
    localparam logic [addrWidth-1:0] fastBase   = 8'h80;
    localparam logic [addrWidth-1:0] sumAddr    = 8'hc0;

    typedef struct packed {
        logic [addrWidth-1:0] paddr;
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [dataWidth-1:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [dataWidth-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apbRsp_t;

    typedef enum logic [2:0] {
        AMP_IN,
        CTRL,
        STATUS,
        LEVEL_OUT,
        FAST_OUT,
        SUM_OUT,
        UNMAPPED
    } regRegion_e;

endpackage

// ==== logic/apbNoteRegs.sv ====
`timescale 1ns/1ps

module apbNoteRegs (
    input  logic                     clk,
    input  logic                     rst,
    input  apbBusPkg::apbReq_t       apbReq_i,
    input  logic                     mapBusy_i,     // mapper is dividing
    input  logic                     frameValid_i,  // mapper finished a frame
    input  fixPointPkg::levelFrame_t levels_i,
    input  fixPointPkg::filterOut_t  filtRes_i,     // result latched by the mapper
    output apbBusPkg::apbRsp_t       apbRsp_o,
    output fixPointPkg::ampFrame_t   ampFrame_o,    // snapshot taken at start
    output logic                     start_o
);
    import fixPointPkg::*;
    import apbBusPkg::*;

    regRegion_e region;
    logic [3:0] wordIdx;                   // entry within a 12-word bank
    logic [addrWidth-1:0] bankBase;
    logic       access;
    logic       wrEn;
    logic       busy;
    logic       startReq;
    logic       inFlight;                  // start issued, mapper not yet busy
    logic       ready;
    ampFrame_t  ampReg;

    assign wordIdx  = apbReq_i.paddr[5:2];
    assign bankBase = {apbReq_i.paddr[7:6], 6'b0};
    assign access   = apbReq_i.psel && apbReq_i.penable;  // completes now, pready is tied high
    assign wrEn     = access && apbReq_i.pwrite;
    assign busy     = inFlight || mapBusy_i;
    assign startReq = wrEn && (region == CTRL) && apbReq_i.pwdata[0] && !busy;  // dropped while busy

    // address decode, unaligned addresses fall through to UNMAPPED
    always_comb begin
        region = UNMAPPED;
        if (apbReq_i.paddr[1:0] == 2'b00) begin
            if (bankBase == ampBase && wordIdx < 4'(binQty)) begin
                region = AMP_IN;
            end else if (apbReq_i.paddr == ctrlAddr) begin
                region = CTRL;
            end else if (apbReq_i.paddr == statusAddr) begin
                region = STATUS;
            end else if (bankBase == levelBase && wordIdx < 4'(binQty)) begin
                region = LEVEL_OUT;
            end else if (bankBase == fastBase && wordIdx < 4'(binQty)) begin
                region = FAST_OUT;
            end else if (apbReq_i.paddr == sumAddr) begin
                region = SUM_OUT;
            end
        end
    end

    // read mux
    always_comb begin
        apbRsp_o.pready  = 1'b1;                              // no wait states
        apbRsp_o.pslverr = access && (region == UNMAPPED);
        case (region)
            AMP_IN:    apbRsp_o.prdata = dataWidth'(ampReg[wordIdx]);
            STATUS:    apbRsp_o.prdata = {30'b0, ready, busy};
            LEVEL_OUT: apbRsp_o.prdata = dataWidth'(levels_i[wordIdx]);
            FAST_OUT:  apbRsp_o.prdata = dataWidth'(filtRes_i.fast[wordIdx]);
            SUM_OUT:   apbRsp_o.prdata = dataWidth'(filtRes_i.newSum);
            default:   apbRsp_o.prdata = '0;                  // ctrl is write-only
        endcase
    end

    // amplitude storage and the frame handed to the filter
    always_ff @(posedge clk) begin
        if (wrEn && region == AMP_IN) begin
            ampReg[wordIdx] <= apbReq_i.pwdata[ampWidth-1:0];
        end
        if (startReq) begin
            ampFrame_o <= ampReg;  // host may rewrite ampReg during the run
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_o  <= 1'b0;
            inFlight <= 1'b0;
            ready    <= 1'b0;
        end else begin
            start_o <= startReq;  // one-cycle pulse
            if (startReq) begin
                inFlight <= 1'b1;
            end else if (mapBusy_i) begin
                inFlight <= 1'b0;  // mapper busy takes over the busy bit
            end
            if (startReq) begin
                ready <= 1'b0;
            end else if (frameValid_i) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/fixPointPkg.sv ====
package fixPointPkg;

    // amplitude format is unsigned q5.11, range [0, 31.999]
    localparam int wholeBits = 5;
    localparam int fracBits  = 11;   // resolution ~0.0005
    localparam int ampWidth  = wholeBits + fracBits;

    localparam int binQty   = 12;                          // one bin per semitone
    localparam int sumWidth = ampWidth + $clog2(binQty);   // twelve full-scale bins fit

    // relative floor = sum * floorNum >> floorShift, about a fifth of the total
    localparam int floorNum   = 205;
    localparam int floorShift = 10;

    localparam int levelMax   = 8;                     // full LED bar
    localparam int levelWidth = $clog2(levelMax + 1);  // 0..8 needs 4 bits

    typedef logic [ampWidth-1:0] amp_t;

    typedef amp_t [binQty-1:0] ampFrame_t;   // bin 0 in the low bits

    typedef logic [binQty-1:0][levelWidth-1:0] levelFrame_t;

    // result of the floor filter, consumed by the level mapper
    typedef struct packed {
        ampFrame_t           reduced;  // kept bins lowered by the threshold
        ampFrame_t           fast;     // kept bins at their original value
        logic [sumWidth-1:0] newSum;   // sum of the reduced bins
    } filterOut_t;

endpackage

// ==== logic/ledLevelMapper.sv ====
`timescale 1ns/1ps

module ledLevelMapper (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_i,
    input  fixPointPkg::filterOut_t  res_i,
    output fixPointPkg::levelFrame_t levels_o,
    output logic                     busy_o,
    output logic                     frameValid_o,
    output fixPointPkg::filterOut_t  held_o    // result of the current run
);
    import fixPointPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        FINISH
    } mapState_e;

    mapState_e state;
    logic [3:0] binIdx;
    logic [1:0] bitIdx;                  // quotient bit being resolved, 3 down to 0
    logic [sumWidth+3:0] rem;
    logic [levelWidth-1:0] quot;
    levelFrame_t levelWork;             // levels built up during the run

    filterOut_t src;
    logic [sumWidth+3:0] remIn;
    logic [sumWidth+3:0] divShift;
    logic geq;
    logic [levelWidth-1:0] quotNext;
    logic [levelWidth-1:0] level;
    levelFrame_t levelWorkNext;
    logic stepEn;
    logic lastStep;

    // the first step runs in the valid_i cycle, straight from the filter output
    assign src      = (state == IDLE) ? res_i : held_o;
    assign stepEn   = (state == DIVIDE) || (state == IDLE && valid_i);
    assign lastStep = stepEn && binIdx == 4'(binQty - 1) && bitIdx == 2'd0;
    assign busy_o       = stepEn;
    assign frameValid_o = (state == FINISH);

    // restoring divide, level = floor(8 * reduced / newSum)
    always_comb begin
        remIn    = (bitIdx == 2'd3) ? (sumWidth+4)'({src.reduced[binIdx], 3'b000}) : rem;
        divShift = (sumWidth+4)'(src.newSum) << bitIdx;
        geq      = remIn >= divShift;
        quotNext = (bitIdx == 2'd3) ? '0 : quot;
        quotNext[bitIdx] = geq;
        if (src.newSum == '0) begin
            level = '0;                  // empty frame, divisor would be zero
        end else if (quotNext > levelWidth'(levelMax)) begin
            level = levelWidth'(levelMax);
        end else begin
            level = quotNext;
        end
        levelWorkNext = levelWork;
        if (bitIdx == 2'd0) begin
            levelWorkNext[binIdx] = level;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && valid_i) begin
            held_o <= res_i;             // read back over APB
        end
        if (stepEn) begin
            rem       <= geq ? remIn - divShift : remIn;
            quot      <= quotNext;
            levelWork <= levelWorkNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            binIdx   <= '0;
            bitIdx   <= 2'd3;
            levels_o <= '0;
        end else begin
            case (state)
                IDLE:    if (valid_i) state <= DIVIDE;
                DIVIDE: begin
                    if (lastStep) begin
                        state    <= FINISH;
                        levels_o <= levelWorkNext;  // whole frame swaps at once
                    end
                end
                default: state <= IDLE;
            endcase
            if (stepEn) begin
                bitIdx <= bitIdx - 2'd1;    // wraps to 3 for the next bin
                if (bitIdx == 2'd0) begin
                    binIdx <= lastStep ? '0 : binIdx + 4'd1;
                end
            end
        end
    end

endmodule

// ==== logic/visualizerTop.sv ====
`timescale 1ns/1ps

module visualizerTop (
    input  logic                     clk,
    input  logic                     rst,
    input  apbBusPkg::apbReq_t       apbReq_i,
    output apbBusPkg::apbRsp_t       apbRsp_o,
    output fixPointPkg::levelFrame_t ledLevels_o,   // held LED bar levels
    output logic                     frameValid_o
);
    import fixPointPkg::*;

    ampFrame_t  ampFrame;   // captured frame, regs to filter
    logic       start;
    filterOut_t filtRes;
    logic       filtValid;
    filterOut_t heldRes;    // mapper copy for read-back
    logic       mapBusy;

    apbNoteRegs i_apbNoteRegs (
        .clk          (clk),
        .rst          (rst),
        .apbReq_i     (apbReq_i),
        .mapBusy_i    (mapBusy),
        .frameValid_i (frameValid_o),
        .levels_i     (ledLevels_o),
        .filtRes_i    (heldRes),
        .apbRsp_o     (apbRsp_o),
        .ampFrame_o   (ampFrame),
        .start_o      (start)
    );

    ampFloorFilter i_ampFloorFilter (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .amps_i  (ampFrame),
        .res_o   (filtRes),
        .valid_o (filtValid)
    );

    ledLevelMapper i_ledLevelMapper (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (filtValid),
        .res_i        (filtRes),
        .levels_o     (ledLevels_o),
        .busy_o       (mapBusy),
        .frameValid_o (frameValid_o),
        .held_o       (heldRes)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build the visualizer testbench with Verilator, run it, search the log for the pass line

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module visualizerTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed" "$logFile"; then
    exit 0
else
    echo "pass line not found in $logFile"
    exit 1
fi
